// File: common/ni_pkg.sv
// Two virtual channels; BuffDepth must stay a power of two, as buffer pointers wrap by overflow
package ni_pkg;

  // Channel and buffer sizing
  localparam int NumVirtChn   = 2;
  localparam int BuffDepth    = 8;                  // Flits per channel
  localparam int BuffPtrWidth = $clog2(BuffDepth);  // Read and write pointer width
  localparam int PktWidth     = 8;                  // Packet size counter width

  // Plain vector types
  typedef logic [15:0]                   csr_addr_t;  // Register bus address
  typedef logic [31:0]                   csr_data_t;  // Register data word
  typedef logic [31:0]                   flit_t;      // Flit payload
  typedef logic [$clog2(NumVirtChn)-1:0] vc_id_t;     // Channel index
  typedef logic [15:0]                   vc_ocup_t;   // Buffer occupancy
  typedef logic [PktWidth-1:0]           pkt_size_t;  // Flits in one packet
  typedef logic [NumVirtChn-1:0]         vc_mask_t;   // One bit per channel

  // Register window in the bus address space
  localparam csr_addr_t CsrBaseAddr = 16'h1000;

  // Byte offsets from CsrBaseAddr
  localparam csr_addr_t CsrVersion     = 16'h0000;  // RO
  localparam csr_addr_t CsrRouterX     = 16'h0004;  // RO
  localparam csr_addr_t CsrRouterY     = 16'h0008;  // RO
  localparam csr_addr_t CsrIrqStatus   = 16'h000C;  // RO, irq vector
  localparam csr_addr_t CsrIrqMux      = 16'h0010;  // RW, interrupt select
  localparam csr_addr_t CsrIrqMask     = 16'h0014;  // RW, mask or threshold
  // Packet sizes, one word per channel
  localparam csr_addr_t CsrPktSizeBase = 16'h0018;
  localparam csr_addr_t CsrPktSize0    = CsrPktSizeBase;
  localparam csr_addr_t CsrPktSize1    = CsrPktSizeBase + 16'h0004;

  // Identifier word, "NI" plus version 1.0
  localparam csr_data_t NiVersion = 32'h4E490100;

  // Interrupt source select
  typedef enum logic [1:0] {
    IrqDefault = 2'd0,  // Not empty
    IrqEmpty   = 2'd1,  // Not empty, masked
    IrqFull    = 2'd2,  // Full, masked
    IrqComp    = 2'd3   // Occupancy against threshold
  } irq_mux_t;

  // Ownership of the shared register bus
  typedef enum logic {
    OwnHost = 1'b0,
    OwnDbg  = 1'b1
  } arb_owner_t;

endpackage

// File: src/csr_arbiter.sv
// Two-way round robin for a slave with ready tied high; requesters must hold valid until ready
`timescale 1ns/1ps

module csr_arbiter import ni_pkg::*; (
  input  logic      clk_axi,
  input  logic      arst_axi,
  // Host requester
  input  logic      host_valid_i,
  input  logic      host_wr_i,
  input  csr_addr_t host_addr_i,
  input  csr_data_t host_wdata_i,
  output logic      host_ready_o,
  output logic      host_resp_valid_o,
  // Debug requester
  input  logic      dbg_valid_i,
  input  logic      dbg_wr_i,
  input  csr_addr_t dbg_addr_i,
  input  csr_data_t dbg_wdata_i,
  output logic      dbg_ready_o,
  output logic      dbg_resp_valid_o,
  // Towards the register block
  output logic      req_valid_o,
  output logic      req_wr_o,
  output csr_addr_t req_addr_o,
  output csr_data_t req_wdata_o,
  input  logic      resp_valid_i
);
  // Owner of the latest accepted request and of its pending response
  arb_owner_t owner_ff;

  // A lone requester always wins; on a conflict the peer of the last owner wins
  assign host_ready_o = host_valid_i & (~dbg_valid_i | (owner_ff == OwnDbg));
  assign dbg_ready_o  = dbg_valid_i & (~host_valid_i | (owner_ff == OwnHost));

  always_comb begin : req_mux
    req_valid_o = host_ready_o | dbg_ready_o;  // Slave never stalls
    if (dbg_ready_o) begin
      req_wr_o    = dbg_wr_i;
      req_addr_o  = dbg_addr_i;
      req_wdata_o = dbg_wdata_i;
    end else begin
      req_wr_o    = host_wr_i;   // Also the idle value
      req_addr_o  = host_addr_i;
      req_wdata_o = host_wdata_i;
    end
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      owner_ff <= OwnDbg;  // Host wins the first conflict
    end else if (host_ready_o) begin
      owner_ff <= OwnHost;
    end else if (dbg_ready_o) begin
      owner_ff <= OwnDbg;
    end
  end

  // Response lands one cycle after accept while owner_ff still names that requester
  assign host_resp_valid_o = resp_valid_i & (owner_ff == OwnHost);
  assign dbg_resp_valid_o  = resp_valid_i & (owner_ff == OwnDbg);

  // Slave answers exactly one cycle after an accept
  a_resp_after_req : assert property (@(posedge clk_axi) disable iff (arst_axi)
    resp_valid_i |-> $past(req_valid_o))
    else $error("Response without an accepted request");

endmodule

// File: csr/ni_csr.sv
// Accepts every request, answers one cycle later; errors on RO writes and unmapped offsets
`timescale 1ns/1ps

module ni_csr import ni_pkg::*; #(
  parameter logic [7:0] RouterXId = 8'd0,
  parameter logic [7:0] RouterYId = 8'd0
) (
  input  logic                       clk_axi,
  input  logic                       arst_axi,
  // Request from the arbiter
  input  logic                       req_valid_i,
  input  logic                       req_wr_i,
  input  csr_addr_t                  req_addr_i,
  input  csr_data_t                  req_wdata_i,
  // Response, one cycle after accept
  output logic                       resp_valid_o,
  output logic                       resp_error_o,
  output csr_data_t                  resp_rdata_o,
  // Buffer status per channel
  input  vc_mask_t                   empty_i,
  input  vc_mask_t                   full_i,
  input  vc_ocup_t  [NumVirtChn-1:0] ocup_i,
  input  pkt_size_t [NumVirtChn-1:0] pkt_size_i,
  // Interrupts
  output vc_mask_t                   irq_vcs_o,
  output logic                       irq_trig_o
);
  csr_addr_t offset;         // Address relative to the window
  csr_data_t decoded_data;   // Read mux output
  logic      error_wr;
  logic      error_rd;
  logic      resp_valid_ff;
  logic      error_ff;       // Read and write errors alike
  csr_data_t rdata_ff;
  csr_data_t next_rdata;
  irq_mux_t  irq_mux_ff;
  irq_mux_t  next_irq_mux;
  csr_data_t irq_mask_ff;    // Bit per channel or threshold in [15:0]
  csr_data_t next_irq_mask;

  assign offset = req_addr_i - CsrBaseAddr;

  always_comb begin : csr_decoder_w
    error_wr      = 1'b0;
    next_irq_mux  = irq_mux_ff;
    next_irq_mask = irq_mask_ff;
    if (req_valid_i && req_wr_i) begin
      case (offset)
        CsrIrqMux:  next_irq_mux = irq_mux_t'(req_wdata_i[1:0]);  // Upper bits ignored
        CsrIrqMask: next_irq_mask = req_wdata_i;
        default:    error_wr = 1'b1;  // RO or unmapped
      endcase
    end
  end

  always_comb begin : csr_decoder_r
    error_rd     = 1'b0;
    decoded_data = '0;
    if (req_valid_i && !req_wr_i) begin
      case (offset)
        CsrVersion:   decoded_data = NiVersion;
        CsrRouterX:   decoded_data = csr_data_t'(RouterXId);
        CsrRouterY:   decoded_data = csr_data_t'(RouterYId);
        CsrIrqStatus: decoded_data = csr_data_t'(irq_vcs_o);  // Live vector
        CsrIrqMux:    decoded_data = csr_data_t'(irq_mux_ff);
        CsrIrqMask:   decoded_data = irq_mask_ff;
        default: begin
          // Packet size words sit one per channel after the base
          error_rd = 1'b1;
          for (int i = 0; i < NumVirtChn; i++) begin
            if (offset == csr_addr_t'(CsrPktSizeBase + 4 * i)) begin
              decoded_data = csr_data_t'(pkt_size_i[i]);
              error_rd     = 1'b0;
            end
          end
        end
      endcase
    end
    // Error keeps the previous read data
    next_rdata = (req_valid_i && !req_wr_i && !error_rd) ? decoded_data : rdata_ff;
  end

  always_comb begin : irq_gen
    irq_vcs_o = '0;
    for (int i = 0; i < NumVirtChn; i++) begin
      case (irq_mux_ff)
        IrqDefault: irq_vcs_o[i] = ~empty_i[i];
        IrqEmpty:   irq_vcs_o[i] = ~empty_i[i] & irq_mask_ff[i];
        IrqFull:    irq_vcs_o[i] = full_i[i] & irq_mask_ff[i];
        IrqComp:    irq_vcs_o[i] = (ocup_i[i] >= irq_mask_ff[15:0]);  // Threshold
        default:    irq_vcs_o[i] = ~empty_i[i];
      endcase
    end
  end

  assign irq_trig_o = |irq_vcs_o;  // Any channel

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      resp_valid_ff <= 1'b0;
      error_ff      <= 1'b0;
      rdata_ff      <= '0;
      irq_mux_ff    <= IrqDefault;
      irq_mask_ff   <= '1;  // All channels enabled
    end else begin
      resp_valid_ff <= req_valid_i;
      error_ff      <= error_rd | error_wr;
      rdata_ff      <= next_rdata;
      irq_mux_ff    <= next_irq_mux;
      irq_mask_ff   <= next_irq_mask;
    end
  end

  assign resp_valid_o = resp_valid_ff;
  assign resp_error_o = error_ff;
  assign resp_rdata_o = rdata_ff;

endmodule

// File: vc_buffer/vc_rd_buffer.sv
// First-word-fall-through FIFO, depth a power of two; writer must not push full, reader not pop empty
`timescale 1ns/1ps

module vc_rd_buffer import ni_pkg::*; (
  input  logic      clk_axi,
  input  logic      arst_axi,
  // Write side, from the router
  input  logic      wr_en_i,
  input  flit_t     wr_data_i,
  input  logic      wr_last_i,   // Closes a packet
  // Read side, head flit always visible
  input  logic      rd_pop_i,
  output flit_t     rd_data_o,
  // Status
  output logic      empty_o,
  output logic      full_o,
  output vc_ocup_t  ocup_o,
  output pkt_size_t pkt_size_o   // Length of the last complete packet
);
  flit_t                   mem [BuffDepth];
  logic [BuffPtrWidth-1:0] wr_ptr_ff;
  logic [BuffPtrWidth-1:0] rd_ptr_ff;
  vc_ocup_t                ocup_ff;
  pkt_size_t               flit_cnt_ff;  // Flits of the packet in progress
  pkt_size_t               pkt_size_ff;
  logic                    push;
  logic                    pop;

  // Misuse is dropped here and flagged by the assertions below
  assign push = wr_en_i & ~full_o;
  assign pop  = rd_pop_i & ~empty_o;

  assign empty_o    = (ocup_ff == '0);
  assign full_o     = (ocup_ff == vc_ocup_t'(BuffDepth));
  assign ocup_o     = ocup_ff;
  assign rd_data_o  = mem[rd_ptr_ff];  // Fall through
  assign pkt_size_o = pkt_size_ff;

  always_ff @(posedge clk_axi) begin
    if (push) begin
      mem[wr_ptr_ff] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_axi or posedge arst_axi) begin
    if (arst_axi) begin
      wr_ptr_ff   <= '0;
      rd_ptr_ff   <= '0;
      ocup_ff     <= '0;
      flit_cnt_ff <= '0;
      pkt_size_ff <= '0;
    end else begin
      if (push) begin
        wr_ptr_ff <= wr_ptr_ff + 1'b1;  // Wraps at BuffDepth
      end
      if (pop) begin
        rd_ptr_ff <= rd_ptr_ff + 1'b1;
      end
      // Push and pop together cancel out
      case ({push, pop})
        2'b10:   ocup_ff <= ocup_ff + 1'b1;
        2'b01:   ocup_ff <= ocup_ff - 1'b1;
        default: ocup_ff <= ocup_ff;
      endcase
      if (push) begin
        if (wr_last_i) begin
          pkt_size_ff <= flit_cnt_ff + 1'b1;  // Last flit counts too
          flit_cnt_ff <= '0;
        end else begin
          flit_cnt_ff <= flit_cnt_ff + 1'b1;
        end
      end
    end
  end

  // Router honours the full flag
  a_no_write_full : assert property (@(posedge clk_axi) disable iff (arst_axi)
    wr_en_i |-> !full_o)
    else $error("Flit written into a full channel");

  // Reader honours the empty flag
  a_no_pop_empty : assert property (@(posedge clk_axi) disable iff (arst_axi)
    rd_pop_i |-> !empty_o)
    else $error("Pop from an empty channel");

endmodule

// File: src/ni_rx_top.sv
// Receive side only, single clock; flits are never sent into a full channel
`timescale 1ns/1ps

module ni_rx_top import ni_pkg::*; #(
  parameter logic [7:0] RouterXId = 8'd0,
  parameter logic [7:0] RouterYId = 8'd0
) (
  input  logic                   clk_axi,
  input  logic                   arst_axi,
  // Host requester
  input  logic                   host_valid_i,
  input  logic                   host_wr_i,
  input  csr_addr_t              host_addr_i,
  input  csr_data_t              host_wdata_i,
  output logic                   host_ready_o,
  output logic                   host_resp_valid_o,
  // Debug requester
  input  logic                   dbg_valid_i,
  input  logic                   dbg_wr_i,
  input  csr_addr_t              dbg_addr_i,
  input  csr_data_t              dbg_wdata_i,
  output logic                   dbg_ready_o,
  output logic                   dbg_resp_valid_o,
  // Shared by both requesters
  output logic                   resp_error_o,
  output csr_data_t              resp_rdata_o,
  // Flits from the router
  input  logic                   flit_valid_i,
  input  vc_id_t                 flit_vc_i,
  input  flit_t                  flit_data_i,
  input  logic                   flit_last_i,
  // Local reader
  input  vc_mask_t               rd_pop_i,
  output flit_t [NumVirtChn-1:0] rd_data_o,
  // Interrupts
  output vc_mask_t               irq_vcs_o,
  output logic                   irq_trig_o
);
  logic                       req_valid;
  logic                       req_wr;
  csr_addr_t                  req_addr;
  csr_data_t                  req_wdata;
  logic                       resp_valid;
  vc_mask_t                   empty;
  vc_mask_t                   full;
  vc_ocup_t  [NumVirtChn-1:0] ocup;
  pkt_size_t [NumVirtChn-1:0] pkt_size;

  csr_arbiter u_arbiter (
    .clk_axi           (clk_axi),
    .arst_axi          (arst_axi),
    .host_valid_i      (host_valid_i),
    .host_wr_i         (host_wr_i),
    .host_addr_i       (host_addr_i),
    .host_wdata_i      (host_wdata_i),
    .host_ready_o      (host_ready_o),
    .host_resp_valid_o (host_resp_valid_o),
    .dbg_valid_i       (dbg_valid_i),
    .dbg_wr_i          (dbg_wr_i),
    .dbg_addr_i        (dbg_addr_i),
    .dbg_wdata_i       (dbg_wdata_i),
    .dbg_ready_o       (dbg_ready_o),
    .dbg_resp_valid_o  (dbg_resp_valid_o),
    .req_valid_o       (req_valid),
    .req_wr_o          (req_wr),
    .req_addr_o        (req_addr),
    .req_wdata_o       (req_wdata),
    .resp_valid_i      (resp_valid)
  );

  ni_csr #(
    .RouterXId (RouterXId),
    .RouterYId (RouterYId)
  ) u_csr (
    .clk_axi      (clk_axi),
    .arst_axi     (arst_axi),
    .req_valid_i  (req_valid),
    .req_wr_i     (req_wr),
    .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),
    .resp_valid_o (resp_valid),
    .resp_error_o (resp_error_o),
    .resp_rdata_o (resp_rdata_o),
    .empty_i      (empty),
    .full_i       (full),
    .ocup_i       (ocup),
    .pkt_size_i   (pkt_size),
    .irq_vcs_o    (irq_vcs_o),
    .irq_trig_o   (irq_trig_o)
  );

  // One buffer per channel, written when the flit carries its index
  for (genvar v = 0; v < NumVirtChn; v++) begin : g_vc
    vc_rd_buffer u_buffer (
      .clk_axi    (clk_axi),
      .arst_axi   (arst_axi),
      .wr_en_i    (flit_valid_i && (flit_vc_i == vc_id_t'(v))),
      .wr_data_i  (flit_data_i),
      .wr_last_i  (flit_last_i),
      .rd_pop_i   (rd_pop_i[v]),
      .rd_data_o  (rd_data_o[v]),
      .empty_o    (empty[v]),
      .full_o     (full[v]),
      .ocup_o     (ocup[v]),
      .pkt_size_o (pkt_size[v])
    );
  end

endmodule

// File: tests/tb_ni_rx.sv
// Fixed seed 32'hf943; outputs sampled on the falling edge, each wait gives up after Timeout cycles
`timescale 1ns/1ps

module tb_ni_rx import ni_pkg::*; ();
  localparam logic [7:0] RouterX = 8'd3;
  localparam logic [7:0] RouterY = 8'd5;
  localparam int         Timeout = 20;  // Cycles per wait

  logic                   clk_axi;
  logic                   arst_axi;
  logic                   host_valid_i;
  logic                   host_wr_i;
  logic                   host_ready_o;
  logic                   host_resp_valid_o;
  csr_addr_t              host_addr_i;
  csr_data_t              host_wdata_i;
  logic                   dbg_valid_i;
  logic                   dbg_wr_i;
  logic                   dbg_ready_o;
  logic                   dbg_resp_valid_o;
  csr_addr_t              dbg_addr_i;
  csr_data_t              dbg_wdata_i;
  logic                   resp_error_o;
  csr_data_t              resp_rdata_o;
  logic                   flit_valid_i;
  logic                   flit_last_i;
  vc_id_t                 flit_vc_i;
  flit_t                  flit_data_i;
  vc_mask_t               rd_pop_i;
  flit_t [NumVirtChn-1:0] rd_data_o;
  vc_mask_t               irq_vcs_o;
  logic                   irq_trig_o;

  // Model of the register block and the channel contents
  irq_mux_t    mux_m;
  csr_data_t   mask_m;
  csr_data_t   rdata_m;             // Last good read
  flit_t       vc_q [NumVirtChn][$];
  pkt_size_t   pkt_m [NumVirtChn];  // Last complete packet
  pkt_size_t   cnt_m [NumVirtChn];  // Packet in progress
  logic        grant_order [$];     // 1 for a debug grant
  int unsigned errors = 0;
  int unsigned checks = 0;

  ni_rx_top #(.RouterXId(RouterX), .RouterYId(RouterY)) DUT (.*);

  initial begin
    clk_axi = 1'b0;
    forever #5 clk_axi = ~clk_axi;
  end

  // Expected interrupt vector from the model
  function automatic vc_mask_t ref_irq();
    vc_mask_t irq;
    int       n;
    for (int i = 0; i < NumVirtChn; i++) begin
      n = vc_q[i].size();
      case (mux_m)
        IrqEmpty: irq[i] = (n != 0) && mask_m[i];
        IrqFull:  irq[i] = (n == BuffDepth) && mask_m[i];
        IrqComp:  irq[i] = n >= int'(mask_m[15:0]);  // Threshold
        default:  irq[i] = (n != 0);                  // Any flit waiting
      endcase
    end
    return irq;
  endfunction

  // Expected {error, data} of a read at a window offset
  function automatic logic [32:0] ref_read(csr_addr_t off);
    case (off)
      CsrVersion:   return {1'b0, NiVersion};
      CsrRouterX:   return {1'b0, 24'd0, RouterX};
      CsrRouterY:   return {1'b0, 24'd0, RouterY};
      CsrIrqStatus: return {1'b0, csr_data_t'(ref_irq())};
      CsrIrqMux:    return {1'b0, csr_data_t'(mux_m)};
      CsrIrqMask:   return {1'b0, mask_m};
      CsrPktSize0:  return {1'b0, csr_data_t'(pkt_m[0])};
      CsrPktSize1:  return {1'b0, csr_data_t'(pkt_m[1])};
      default:      return {1'b1, rdata_m};  // Old data repeated
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // One request on the host or debug port with its response checked against the model
  task automatic csr_op(input bit dbg, input bit wr, input csr_addr_t off, input csr_data_t wdata);
    logic [32:0] expected;
    logic        seen;
    int          n;
    expected = wr ? {1'b0, rdata_m} : ref_read(off);
    if (wr) expected[32] = !(off inside {CsrIrqMux, CsrIrqMask});  // Only two writable
    @(posedge clk_axi);
    if (dbg) begin
      {dbg_valid_i, dbg_wr_i, dbg_addr_i, dbg_wdata_i} <= {1'b1, wr, CsrBaseAddr + off, wdata};
    end else begin
      {host_valid_i, host_wr_i, host_addr_i, host_wdata_i} <= {1'b1, wr, CsrBaseAddr + off, wdata};
    end
    n = 0;
    do begin
      @(negedge clk_axi);
      seen = dbg ? dbg_ready_o : host_ready_o;
      n++;
    end while (!seen && n < Timeout);
    if (!seen) begin
      errors++;
      $display("Timeout: the %s port was never granted", dbg ? "debug" : "host");
    end else begin
      grant_order.push_back(dbg);
    end
    @(posedge clk_axi);  // Accept edge
    if (dbg) begin
      dbg_valid_i <= 1'b0;
    end else begin
      host_valid_i <= 1'b0;
    end
    n = 0;
    do begin
      @(negedge clk_axi);
      seen = dbg ? dbg_resp_valid_o : host_resp_valid_o;
      n++;
    end while (!seen && n < Timeout);
    if (!seen) begin
      errors++;
      $display("Timeout: no response strobe on the %s port", dbg ? "debug" : "host");
    end
    check_value("peer resp_valid", dbg ? host_resp_valid_o : dbg_resp_valid_o, 1'b0);
    check_value("resp_error_o", resp_error_o, expected[32]);
    check_value("resp_rdata_o", resp_rdata_o, expected[31:0]);
    if (wr && !expected[32] && off == CsrIrqMux) mux_m = irq_mux_t'(wdata[1:0]);
    if (wr && !expected[32] && off == CsrIrqMask) mask_m = wdata;
    if (!wr && !expected[32]) rdata_m = expected[31:0];
  endtask

  // Drives one flit for a cycle and mirrors it
  task automatic push_flit(input int vc, input logic last);
    flit_t data;
    data = $urandom;
    @(posedge clk_axi);
    flit_valid_i <= 1'b1;
    flit_vc_i    <= vc_id_t'(vc);
    flit_data_i  <= data;
    flit_last_i  <= last;
    vc_q[vc].push_back(data);
    cnt_m[vc] = cnt_m[vc] + 1'b1;
    if (last) begin
      pkt_m[vc] = cnt_m[vc];  // Last flit included
      cnt_m[vc] = '0;
    end
  endtask

  task automatic flit_idle();
    @(posedge clk_axi);
    flit_valid_i <= 1'b0;
  endtask

  // Head flit checked before each pop
  task automatic pop_flit(input int vc);
    @(negedge clk_axi);
    check_value($sformatf("rd_data_o[%0d]", vc), rd_data_o[vc], vc_q[vc][0]);
    @(posedge clk_axi);
    rd_pop_i[vc] <= 1'b1;
    @(posedge clk_axi);
    rd_pop_i <= '0;
    void'(vc_q[vc].pop_front());
  endtask

  task automatic set_fill(input int vc, input int target);
    if (vc_q[vc].size() < target) begin
      while (vc_q[vc].size() < target) push_flit(vc, 1'($urandom % 2));  // Random packet ends
      flit_idle();
    end
    while (vc_q[vc].size() > target) pop_flit(vc);
  endtask

  // Interrupt pins and CsrIrqStatus against ref_irq
  task automatic check_irq();
    vc_mask_t expected;
    @(negedge clk_axi);
    expected = ref_irq();
    check_value("irq_vcs_o", irq_vcs_o, expected);
    check_value("irq_trig_o", irq_trig_o, |expected);
    csr_op(1'b0, 1'b0, CsrIrqStatus, '0);
  endtask

  initial begin
    int        room;
    int        len;
    int        base;
    csr_data_t mask;
    void'($urandom(32'hf943));
    arst_axi     = 1'b1;
    host_valid_i = 1'b0;
    host_wr_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    dbg_valid_i  = 1'b0;
    dbg_wr_i     = 1'b0;
    dbg_addr_i   = '0;
    dbg_wdata_i  = '0;
    flit_valid_i = 1'b0;
    flit_vc_i    = '0;
    flit_data_i  = '0;
    flit_last_i  = 1'b0;
    rd_pop_i     = '0;
    mux_m        = IrqDefault;
    mask_m       = '1;
    rdata_m      = '0;
    pkt_m        = '{default: '0};
    cnt_m        = '{default: '0};
    repeat (2) @(posedge clk_axi);
    arst_axi <= 1'b0;

    // State right after reset
    @(negedge clk_axi);
    check_value("irq_trig_o", irq_trig_o, 1'b0);
    check_value("host_resp_valid_o", host_resp_valid_o, 1'b0);
    check_value("dbg_resp_valid_o", dbg_resp_valid_o, 1'b0);
    check_value("resp_rdata_o", resp_rdata_o, '0);
    csr_op(1'b0, 1'b0, CsrVersion, '0);
    csr_op(1'b0, 1'b0, CsrRouterX, '0);
    csr_op(1'b0, 1'b0, CsrRouterY, '0);
    csr_op(1'b0, 1'b0, CsrIrqMux, '0);
    csr_op(1'b0, 1'b0, CsrIrqMask, '0);

    // Read back of writable registers and the two error cases
    mask = $urandom;
    csr_op(1'b0, 1'b1, CsrIrqMux, csr_data_t'(IrqFull));
    csr_op(1'b0, 1'b0, CsrIrqMux, '0);
    csr_op(1'b0, 1'b1, CsrIrqMask, mask);
    csr_op(1'b0, 1'b1, CsrVersion, 32'hdead_beef);  // RO target
    csr_op(1'b0, 1'b0, CsrIrqMask, '0);
    csr_op(1'b0, 1'b0, 16'h0040, '0);               // Unmapped
    csr_op(1'b0, 1'b0, CsrIrqMux, '0);
    csr_op(1'b0, 1'b0, CsrVersion, '0);

    // Random length packets until both channels are full
    csr_op(1'b0, 1'b1, CsrIrqMask, '1);
    for (int vc = 0; vc < NumVirtChn; vc++) begin
      room = BuffDepth;
      while (room > 0) begin
        len = 1 + $urandom % 4;
        if (len > room) len = room;
        for (int f = 0; f < len; f++) push_flit(vc, f == len - 1);
        room -= len;
      end
    end
    flit_idle();
    check_irq();  // Full flags
    csr_op(1'b0, 1'b0, CsrPktSize0, '0);
    csr_op(1'b0, 1'b0, CsrPktSize1, '0);
    csr_op(1'b0, 1'b1, CsrIrqMux, csr_data_t'(IrqDefault));
    for (int vc = 0; vc < NumVirtChn; vc++) set_fill(vc, 0);
    check_irq();  // Both drained

    // Each select mode with random masks and fills
    for (int m = 0; m < 4; m++) begin
      csr_op(1'b0, 1'b1, CsrIrqMux, csr_data_t'(m));
      repeat (4) begin
        for (int vc = 0; vc < NumVirtChn; vc++) set_fill(vc, $urandom % (BuffDepth + 1));
        mask = (m == IrqComp) ? $urandom % (BuffDepth + 2) : $urandom;  // Small threshold
        csr_op(1'b0, 1'b1, CsrIrqMask, mask);
        check_irq();
      end
    end

    // Host and debug raised together for three rounds
    base = grant_order.size();
    repeat (3) begin
      fork
        csr_op(1'b0, 1'b0, CsrRouterX, '0);
        csr_op(1'b1, 1'b0, CsrRouterY, '0);
      join
    end
    check_value("grant count", grant_order.size() - base, 6);
    for (int i = base; i < grant_order.size(); i++) begin
      check_value("grant owner", grant_order[i], !grant_order[i - 1]);  // Round robin
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/ni_pkg.sv
src/csr_arbiter.sv
csr/ni_csr.sv
vc_buffer/vc_rd_buffer.sv
src/ni_rx_top.sv
tests/tb_ni_rx.sv

// File: Bender.yml
package:
  name: ni_rx

sources:
  # Package first, then leaf modules, then the top level
  - common/ni_pkg.sv
  - src/csr_arbiter.sv
  - csr/ni_csr.sv
  - vc_buffer/vc_rd_buffer.sv
  - src/ni_rx_top.sv

  # Testbench, top module tb_ni_rx
  - target: test
    files:
      - tests/tb_ni_rx.sv
